// File: design/memPkg.sv
// Bus widths, memory geometry, wait-state count and arbiter state type
package memPkg;

  // Byte address width on the shared bus
  localparam int ADDR_WIDTH = 32;

  // Bus word and byte lanes
  localparam int DATA_WIDTH = 32;
  localparam int MASK_WIDTH = 4;
  localparam int LANE_WIDTH = DATA_WIDTH / MASK_WIDTH;

  // Storage depth in words
  localparam int MEM_WORDS = 256;

  // Word index taken from address bits above the byte offset
  // Upper address bits are dropped so the window aliases
  localparam int INDEX_WIDTH = $clog2(MEM_WORDS);

  // Wait states inserted per transfer, must be at least 1
  localparam int WAIT_CYCLES = 2;

  // Counter width able to hold WAIT_CYCLES
  localparam int WAIT_WIDTH = $clog2(WAIT_CYCLES + 1);

  // Bus owner
  // ARB_IDLE   no owner, requests are sampled here
  // ARB_FETCH  fetch port holds the bus
  // ARB_DATA   data port holds the bus
  typedef enum logic [1:0] {
    ARB_IDLE  = 2'd0,
    ARB_FETCH = 2'd1,
    ARB_DATA  = 2'd2
  } arbState;

endpackage

// File: design/busArbiter.sv
// Bus arbiter FSM with fetch/data grant, address and control mux, ready pulses
`timescale 1ns/1ps

module busArbiter (
  input  logic                          clk,
  input  logic                          rstN,
  // Fetch requester
  input  logic                          fReq,
  input  logic [memPkg::ADDR_WIDTH-1:0] fAddr,
  // Data requester
  input  logic                          mReq,
  input  logic                          mWrite,
  input  logic [memPkg::ADDR_WIDTH-1:0] mAddr,
  input  logic [memPkg::DATA_WIDTH-1:0] mWData,
  input  logic [memPkg::MASK_WIDTH-1:0] mMask,
  // From wait timer
  input  logic                          done,
  // To wait timer and memory
  output logic                          start,
  output logic [memPkg::ADDR_WIDTH-1:0] haddr,
  output logic                          hwrite,
  output logic [memPkg::DATA_WIDTH-1:0] hwdata,
  output logic [memPkg::MASK_WIDTH-1:0] hmask,
  // Back to requesters
  output logic                          fReady,
  output logic                          mReady,
  output memPkg::arbState               state
);
  import memPkg::*;

  // Previous grant went to the data port
  logic lastData;
  logic anyReq;
  logic pickData;

  assign anyReq = fReq | mReq;

  // Data wins a tie unless it also won the last grant
  assign pickData = mReq & (~fReq | ~lastData);

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      state    <= ARB_IDLE;
      lastData <= 1'b0;
      start    <= 1'b0;
      fReady   <= 1'b0;
      mReady   <= 1'b0;
    end
    else
    begin
      // Pulses default low
      start  <= 1'b0;
      fReady <= 1'b0;
      mReady <= 1'b0;
      case (state)
        ARB_IDLE:
        begin
          if (anyReq)
          begin
            state    <= pickData ? ARB_DATA : ARB_FETCH;
            lastData <= pickData;
            // Kick off the wait states
            start    <= 1'b1;
          end
        end
        ARB_FETCH:
        begin
          // Hold ownership through the ready cycle
          // so the still-raised request is not sampled again
          if (fReady)
            state <= ARB_IDLE;
          else if (done)
            fReady <= 1'b1;
        end
        ARB_DATA:
        begin
          if (mReady)
            state <= ARB_IDLE;
          else if (done)
            mReady <= 1'b1;
        end
        default:
        begin
          state <= ARB_IDLE;
        end
      endcase
    end
  end

  // Owner's address and controls onto the bus
  always_comb
  begin
    haddr  = mAddr;
    hwrite = 1'b0;
    hmask  = '0;
    case (state)
      ARB_FETCH:
      begin
        // Fetch is read only
        haddr = fAddr;
      end
      ARB_DATA:
      begin
        haddr  = mAddr;
        hwrite = mWrite;
        hmask  = mMask;
      end
      default:
      begin
        haddr = mAddr;
      end
    endcase
  end

  // Write data only ever comes from the data port
  assign hwdata = mWData;

  // One owner, one ready
  aReadyExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(fReady && mReady))
    else $error("fReady and mReady high together");

  // Start follows the grant edge only
  aStartAfterIdle: assert property (@(posedge clk) disable iff (!rstN)
    start |-> ($past(state) == ARB_IDLE) && (state != ARB_IDLE))
    else $error("start outside the grant cycle");

  // Requesters hold their level until the ready pulse is seen
  aFetchHeld: assert property (@(posedge clk) disable iff (!rstN)
    (state == ARB_FETCH) |-> fReq)
    else $error("fetch request dropped before fReady");

  aDataHeld: assert property (@(posedge clk) disable iff (!rstN)
    (state == ARB_DATA) |-> mReq)
    else $error("data request dropped before mReady");

endmodule

// File: design/waitTimer.sv
// Wait-state down-counter with single-cycle done pulse
`timescale 1ns/1ps

module waitTimer (
  input  logic clk,
  input  logic rstN,
  // Load pulse from the arbiter
  input  logic start,
  // Transfer may complete this cycle
  output logic done
);
  import memPkg::*;

  // Remaining wait states, zero when idle
  logic [WAIT_WIDTH-1:0] count;

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      count <= '0;
      done  <= 1'b0;
    end
    else
    begin
      // Last wait state becomes the done cycle
      done <= (count == WAIT_WIDTH'(1));
      if (start)
      begin
        count <= WAIT_WIDTH'(WAIT_CYCLES);
      end
      else if (count != '0)
      begin
        count <= count - 1'b1;
      end
    end
  end

  // Arbiter waits for done before issuing a new start
  aStartWhenIdle: assert property (@(posedge clk) disable iff (!rstN)
    start |-> (count == '0) && !done)
    else $error("start while a wait count is running");

endmodule

// File: design/wordMemory.sv
// Word memory with byte-lane masked writes and registered read port
`timescale 1ns/1ps

module wordMemory (
  input  logic                          clk,
  input  logic                          rstN,
  // Transfer completes this cycle
  input  logic                          done,
  // Shared bus from the arbiter
  input  logic [memPkg::ADDR_WIDTH-1:0] haddr,
  input  logic                          hwrite,
  input  logic [memPkg::DATA_WIDTH-1:0] hwdata,
  input  logic [memPkg::MASK_WIDTH-1:0] hmask,
  // Read word, valid from the cycle after done
  output logic [memPkg::DATA_WIDTH-1:0] rData
);
  import memPkg::*;

  // Storage array
  logic [DATA_WIDTH-1:0]  mem [MEM_WORDS];

  // Word select from address bits 9 to 2
  logic [INDEX_WIDTH-1:0] wordIdx;

  // Transfer qualifiers
  logic                   doWrite;
  logic                   doRead;

  assign wordIdx = haddr[INDEX_WIDTH+1:2];
  assign doWrite = done & hwrite;
  assign doRead  = done & ~hwrite;

  // Byte-lane write
  // Lanes with a clear mask bit keep their old contents
  always_ff @(posedge clk)
  begin
    if (doWrite)
    begin
      for (int lane = 0; lane < MASK_WIDTH; lane++)
      begin
        if (hmask[lane])
        begin
          mem[wordIdx][lane*LANE_WIDTH +: LANE_WIDTH] <=
            hwdata[lane*LANE_WIDTH +: LANE_WIDTH];
        end
      end
    end
  end

  // Read register
  // Holds its value between reads
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      rData <= '0;
    end
    else if (doRead)
    begin
      rData <= mem[wordIdx];
    end
  end

  // Only word-aligned transfers reach the array
  aWordAligned: assert property (@(posedge clk) disable iff (!rstN)
    done |-> (haddr[1:0] == 2'b00))
    else $error("unaligned address 0x%08h on done", haddr);

  // Address and controls stay put from the previous cycle into done
  aBusStable: assert property (@(posedge clk) disable iff (!rstN)
    done |-> $stable(haddr) && $stable(hwrite))
    else $error("bus changed while the transfer was waiting");

endmodule

// File: design/memTop.sv
// Top level with arbiter, wait timer and word memory behind fetch and data ports
`timescale 1ns/1ps

module memTop (
  input  logic                          clk,
  input  logic                          rstN,
  // Fetch port, would face the instruction side
  input  logic                          fReq,
  input  logic [memPkg::ADDR_WIDTH-1:0] fAddr,
  output logic                          fReady,
  // Data port, would face the load/store side
  input  logic                          mReq,
  input  logic                          mWrite,
  input  logic [memPkg::ADDR_WIDTH-1:0] mAddr,
  input  logic [memPkg::DATA_WIDTH-1:0] mWData,
  input  logic [memPkg::MASK_WIDTH-1:0] mMask,
  output logic                          mReady,
  // Shared read data
  output logic [memPkg::DATA_WIDTH-1:0] rData,
  // Debug view of the owner
  output memPkg::arbState               state
);
  import memPkg::*;

  // Internal bus
  logic                  start;
  logic                  done;
  logic [ADDR_WIDTH-1:0] haddr;
  logic                  hwrite;
  logic [DATA_WIDTH-1:0] hwdata;
  logic [MASK_WIDTH-1:0] hmask;

  // Who owns the bus
  busArbiter u_arb (
    .clk   (clk   ),
    .rstN  (rstN  ),
    .fReq  (fReq  ),
    .fAddr (fAddr ),
    .mReq  (mReq  ),
    .mWrite(mWrite),
    .mAddr (mAddr ),
    .mWData(mWData),
    .mMask (mMask ),
    .done  (done  ),
    .start (start ),
    .haddr (haddr ),
    .hwrite(hwrite),
    .hwdata(hwdata),
    .hmask (hmask ),
    .fReady(fReady),
    .mReady(mReady),
    .state (state )
  );

  // Wait states
  waitTimer u_timer (
    .clk  (clk  ),
    .rstN (rstN ),
    .start(start),
    .done (done )
  );

  // On-chip storage
  wordMemory u_mem (
    .clk   (clk   ),
    .rstN  (rstN  ),
    .done  (done  ),
    .haddr (haddr ),
    .hwrite(hwrite),
    .hwdata(hwdata),
    .hmask (hmask ),
    .rData (rData )
  );

endmodule

// File: testbench/memModel.svh
// Reference memory, LCG generator, arbitration model and value check for the memTop testbench
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

// Reference copy of the word memory
logic [DATA_WIDTH-1:0] modelMem [MEM_WORDS];

// Arbiter mirror, its own copy of the last grant
logic    modelLastData;
arbState modelOwner;

// Generator state and run bookkeeping
logic [31:0] lcgState;
string       testName;
int          errorCount;
int          checkCount;

// Numerical Recipes constants
function automatic logic [31:0] nextRand();
  lcgState = lcgState * 32'd1664525 + 32'd1013904223;
  return lcgState;
endfunction

// Low bits of an LCG cycle quickly, so drop them
function automatic int randBelow(int limit);
  return int'(nextRand() >> 8) % limit;
endfunction

// Word index is byte address bits 9 to 2
function automatic logic [INDEX_WIDTH-1:0] wordOf(logic [ADDR_WIDTH-1:0] addr);
  return addr[INDEX_WIDTH+1:2];
endfunction

// Masked lanes take the new byte, the rest keep the old one
function automatic logic [DATA_WIDTH-1:0] mergeLanes(logic [DATA_WIDTH-1:0] oldWord,
                                                     logic [DATA_WIDTH-1:0] newWord,
                                                     logic [MASK_WIDTH-1:0] mask);
  logic [DATA_WIDTH-1:0] laneBits;
  for (int lane = 0; lane < MASK_WIDTH; lane++)
    laneBits[lane*LANE_WIDTH +: LANE_WIDTH] = {LANE_WIDTH{mask[lane]}};
  return (oldWord & ~laneBits) | (newWord & laneBits);
endfunction

// Single requester wins outright
// On a tie data goes first unless it won the previous grant
function automatic arbState predictGrant(logic fWant, logic mWant);
  if (fWant && mWant)
    return modelLastData ? ARB_FETCH : ARB_DATA;
  return mWant ? ARB_DATA : ARB_FETCH;
endfunction

task automatic checkValue(string what, logic [DATA_WIDTH-1:0] expected,
                          logic [DATA_WIDTH-1:0] actual);
  checkCount++;
  if (actual !== expected)
  begin
    errorCount++;
    $display("** Error [%s] %s: expected 0x%08h, actual 0x%08h",
             testName, what, expected, actual);
  end
endtask

`endif

// File: testbench/tbMemTop.sv
// Testbench for memTop with clock, reset, random fetch and data traffic, timeout and report
`timescale 1ns/1ps

module tbMemTop;
  import memPkg::*;

  `include "memModel.svh"

  // Run lengths
  localparam int          RESET_CYCLES = 5;
  localparam int          IDLE_CYCLES  = 6;
  localparam int          MASKED_COUNT = 64;
  localparam int          FETCH_COUNT  = 64;
  localparam int          MIX_ROUNDS   = 100;
  localparam logic [31:0] SEED         = 32'hd9893bf9;

  // Fill, readback twice, masked pairs, fetches, up to two per mixed round
  localparam int TRANSFERS   = 3 * MEM_WORDS + 2 * MASKED_COUNT + FETCH_COUNT + 2 * MIX_ROUNDS;
  localparam int CYCLE_LIMIT = 4 * TRANSFERS * (WAIT_CYCLES + 3) + RESET_CYCLES + IDLE_CYCLES;

  logic                  clk;
  logic                  rstN;
  logic                  fReq;
  logic [ADDR_WIDTH-1:0] fAddr;
  logic                  fReady;
  logic                  mReq;
  logic                  mWrite;
  logic [ADDR_WIDTH-1:0] mAddr;
  logic [DATA_WIDTH-1:0] mWData;
  logic [MASK_WIDTH-1:0] mMask;
  logic                  mReady;
  logic [DATA_WIDTH-1:0] rData;
  arbState               state;
  int                    cycleCount;

  // Pending requests per port, served in issue order
  logic [ADDR_WIDTH-1:0] fetchQ [$];
  logic                  dataWriteQ [$];
  logic [ADDR_WIDTH-1:0] dataAddrQ [$];
  logic [DATA_WIDTH-1:0] dataWordQ [$];
  logic [MASK_WIDTH-1:0] dataMaskQ [$];

  // Request on the port, and ready seen with release due next cycle
  logic fActive;
  logic fFinish;
  logic mActive;
  logic mFinish;

  memTop u_dut (
    .clk   (clk   ),
    .rstN  (rstN  ),
    .fReq  (fReq  ),
    .fAddr (fAddr ),
    .fReady(fReady),
    .mReq  (mReq  ),
    .mWrite(mWrite),
    .mAddr (mAddr ),
    .mWData(mWData),
    .mMask (mMask ),
    .mReady(mReady),
    .rData (rData ),
    .state (state )
  );

  // 8 ns clock
  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Hang guard
  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CYCLE_LIMIT)
    begin
      $display("Timeout after %0d cycles, a port never got its ready", cycleCount);
      $display("Simulation FAILED");
      $finish;
    end
  end

  function automatic logic [ADDR_WIDTH-1:0] randAddr();
    return ADDR_WIDTH'(randBelow(MEM_WORDS)) << 2;
  endfunction

  task automatic queueData(logic write, logic [ADDR_WIDTH-1:0] addr,
                           logic [DATA_WIDTH-1:0] data, logic [MASK_WIDTH-1:0] mask);
    dataWriteQ.push_back(write);
    dataAddrQ.push_back(addr);
    dataWordQ.push_back(data);
    dataMaskQ.push_back(mask);
  endtask

  // One clock, with outputs read and inputs driven 1 ns after the edge
  task automatic stepCycle();
    @(posedge clk);
    #1;
    // Ready was seen last cycle, so the port lets go now
    if (fFinish)
    begin
      fFinish    = 1'b0;
      fActive    = 1'b0;
      fReq       = 1'b0;
      modelOwner = ARB_IDLE;
    end
    if (mFinish)
    begin
      mFinish    = 1'b0;
      mActive    = 1'b0;
      mReq       = 1'b0;
      mWrite     = 1'b0;
      modelOwner = ARB_IDLE;
    end
    // Completions must come from the owner the model granted
    if (fReady)
    begin
      checkValue("fReady owner", 32'(modelOwner), 32'(ARB_FETCH));
      checkValue("fetch rData", modelMem[wordOf(fAddr)], rData);
      fFinish = 1'b1;
    end
    if (mReady)
    begin
      checkValue("mReady owner", 32'(modelOwner), 32'(ARB_DATA));
      if (mWrite)
        modelMem[wordOf(mAddr)] = mergeLanes(modelMem[wordOf(mAddr)], mWData, mMask);
      else
        checkValue("data rData", modelMem[wordOf(mAddr)], rData);
      mFinish = 1'b1;
    end
    // Present the next request of an idle port
    if (!fActive && fetchQ.size() > 0)
    begin
      fAddr   = fetchQ.pop_front();
      fReq    = 1'b1;
      fActive = 1'b1;
    end
    if (!mActive && dataAddrQ.size() > 0)
    begin
      mWrite  = dataWriteQ.pop_front();
      mAddr   = dataAddrQ.pop_front();
      mWData  = dataWordQ.pop_front();
      mMask   = dataMaskQ.pop_front();
      mReq    = 1'b1;
      mActive = 1'b1;
    end
    // Free bus samples these requests at the coming edge
    if (modelOwner == ARB_IDLE && (fReq || mReq))
    begin
      modelOwner    = predictGrant(fReq, mReq);
      modelLastData = (modelOwner == ARB_DATA);
    end
  endtask

  task automatic drainPorts();
    while (fetchQ.size() > 0 || dataAddrQ.size() > 0 || fActive || mActive)
      stepCycle();
  endtask

  initial
  begin
    logic [ADDR_WIDTH-1:0] addr;
    logic [31:0]           rnd;
    lcgState      = SEED;
    errorCount    = 0;
    checkCount    = 0;
    cycleCount    = 0;
    modelLastData = 1'b0;
    modelOwner    = ARB_IDLE;
    fActive       = 1'b0;
    fFinish       = 1'b0;
    mActive       = 1'b0;
    mFinish       = 1'b0;
    rstN          = 1'b0;
    fReq          = 1'b0;
    fAddr         = '0;
    mReq          = 1'b0;
    mWrite        = 1'b0;
    mAddr         = '0;
    mWData        = '0;
    mMask         = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rstN = 1'b1;

    // Quiet bus until the first request
    testName = "resetIdle";
    for (int i = 0; i < IDLE_CYCLES; i++)
    begin
      stepCycle();
      checkValue("fReady", '0, 32'(fReady));
      checkValue("mReady", '0, 32'(mReady));
      checkValue("state", 32'(ARB_IDLE), 32'(state));
      checkValue("rData", '0, rData);
    end

    // Every word written whole, then read back
    testName = "fullWords";
    for (int i = 0; i < MEM_WORDS; i++)
      queueData(1'b1, ADDR_WIDTH'(i) << 2, nextRand(), '1);
    drainPorts();
    testName = "readBack";
    for (int i = 0; i < MEM_WORDS; i++)
      queueData(1'b0, ADDR_WIDTH'(i) << 2, '0, '0);
    drainPorts();

    // Partial lane updates, each followed by a read of the same word
    testName = "maskedWrites";
    for (int i = 0; i < MASKED_COUNT; i++)
    begin
      addr = randAddr();
      queueData(1'b1, addr, nextRand(), MASK_WIDTH'(randBelow(1 << MASK_WIDTH)));
      queueData(1'b0, addr, '0, '0);
    end
    drainPorts();

    // Fetch reads then a full sweep showing memory unchanged
    testName = "fetchReads";
    // Idle data port shows a full-mask write that fetch must never pick up
    mWrite = 1'b1;
    mWData = nextRand();
    mMask  = '1;
    for (int i = 0; i < FETCH_COUNT; i++)
      fetchQ.push_back(randAddr());
    drainPorts();
    testName = "fetchNoWrite";
    for (int i = 0; i < MEM_WORDS; i++)
      queueData(1'b0, ADDR_WIDTH'(i) << 2, '0, '0);
    drainPorts();

    // Both ports in the same cycle or staggered so one waits behind the other
    testName = "mixedPorts";
    for (int r = 0; r < MIX_ROUNDS; r++)
    begin
      rnd = nextRand();
      if (rnd[20])
        fetchQ.push_back(randAddr());
      repeat (rnd[23:22]) stepCycle();
      if (rnd[21])
        queueData(rnd[24], randAddr(), nextRand(), MASK_WIDTH'(randBelow(1 << MASK_WIDTH)));
      drainPorts();
    end

    $display("Checks: %0d  Errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: memTop.f
+incdir+testbench
design/memPkg.sv
design/busArbiter.sv
design/waitTimer.sv
design/wordMemory.sv
design/memTop.sv
testbench/tbMemTop.sv

// File: Makefile
# Verilator build and run for the memTop testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

# Build the simulator binary from the file list
compile:
	verilator --binary --timing --assert -Wno-fatal -f memTop.f \
		--top-module tbMemTop -o simTbMemTop

# Run, keep the log, and fail unless the pass line is there
run: compile
	./obj_dir/simTbMemTop | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
